//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    localparam logic [3:0] DEV_TYPE = 4'b1010;      // control byte device code

    // one quarter of a bus bit in CLK cycles
    localparam int QUARTER_CYCLES = 1;
    localparam int BIT_CYCLES     = 4 * QUARTER_CYCLES;
    localparam int PHASE_W        = $clog2(BIT_CYCLES);

    localparam logic [PHASE_W-1:0] PHASE_LAST   = PHASE_W'(BIT_CYCLES - 1);
    localparam logic [PHASE_W-1:0] PHASE_SAMPLE = PHASE_W'(3 * QUARTER_CYCLES - 1);

    localparam logic [3:0] ACK_BIT = 4'd8;          // ninth slot of a byte

    // sequencer states
    localparam logic [3:0] ST_IDLE    = 4'd0;
    localparam logic [3:0] ST_START   = 4'd1;
    localparam logic [3:0] ST_CTRL    = 4'd2;
    localparam logic [3:0] ST_ADDR    = 4'd3;
    localparam logic [3:0] ST_DATA    = 4'd4;
    localparam logic [3:0] ST_RESTART = 4'd5;
    localparam logic [3:0] ST_CTRL_RD = 4'd6;
    localparam logic [3:0] ST_READ    = 4'd7;
    localparam logic [3:0] ST_STOP    = 4'd8;
    localparam logic [3:0] ST_DONE    = 4'd9;

    typedef logic [10:0] addr_t;
    typedef logic [7:0]  data_t;

    typedef union packed {
        struct packed {
            logic [3:0] dev_type;
            logic [2:0] page;       // addr[10:8]
            logic       rw;         // 1 = read
        } f;
        data_t raw;
    } ctrl_byte_u;

    typedef enum logic [1:0] {COND_START, COND_RESTART, COND_STOP} cond_kind_e;

endpackage

//--- logic/byte_if.sv
`timescale 1ns/1ns
interface byte_if;

    logic              go;
    logic              rx_mode;
    eeprom_pkg::data_t tx_byte;
    logic              master_nack;     // ninth bit value when receiving
    eeprom_pkg::data_t rx_byte;
    logic              slave_ack;
    logic              done;
    logic              scl;
    logic              sda_out;
    logic              sda_in;          // from the pin

    modport seq
    (
        output go, rx_mode, tx_byte, master_nack,
        input  rx_byte, slave_ack, done, scl, sda_out
    );

    modport shifter
    (
        input  go, rx_mode, tx_byte, master_nack, sda_in,
        output rx_byte, slave_ack, done, scl, sda_out
    );

endinterface

//--- logic/cond_if.sv
`timescale 1ns/1ns
interface cond_if;

    logic                   go;
    eeprom_pkg::cond_kind_e kind;
    logic                   done;
    logic                   scl;
    logic                   sda_out;

    modport seq
    (
        output go, kind,
        input  done, scl, sda_out
    );

    modport gen
    (
        input  go, kind,
        output done, scl, sda_out
    );

endinterface

//--- logic/i2c_cond.sv
`timescale 1ns/1ns
module i2c_cond
(
    input logic CLK,
    input logic RESET,
    cond_if.gen c
);

    logic                            active;
    logic [eeprom_pkg::PHASE_W-1:0]  phase;
    logic [1:0]                      quarter;
    eeprom_pkg::cond_kind_e          kind_r;

    assign quarter = 2'(phase / eeprom_pkg::QUARTER_CYCLES);
    assign c.done  = active && (phase == eeprom_pkg::PHASE_LAST);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            phase  <= '0;
        end
        else if (c.go && !active)
        begin
            active <= 1'b1;
            phase  <= '0;
        end
        else if (active)
        begin
            if (phase == eeprom_pkg::PHASE_LAST)
            begin
                active <= 1'b0;
                phase  <= '0;
            end
            else
                phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (c.go && !active)
            kind_r <= c.kind;
    end

    // quarter patterns, bus idles with both lines high
    always_comb
    begin
        c.scl     = 1'b1;
        c.sda_out = 1'b1;
        if (active)
        begin
            case (kind_r)
                eeprom_pkg::COND_START:
                begin
                    c.scl     = (quarter != 2'd3);
                    c.sda_out = (quarter < 2'd2);   // falls while scl high
                end
                eeprom_pkg::COND_RESTART:
                begin
                    c.scl     = (quarter == 2'd1) || (quarter == 2'd2);
                    c.sda_out = (quarter < 2'd2);
                end
                eeprom_pkg::COND_STOP:
                begin
                    c.scl     = (quarter != 2'd0);
                    c.sda_out = (quarter >= 2'd2);  // rises while scl high
                end
                default:
                begin
                    c.scl     = 1'b1;
                    c.sda_out = 1'b1;
                end
            endcase
        end
    end

    a_go_idle: assert property (@(posedge CLK) disable iff (RESET)
        c.go |-> !active);

endmodule

//--- logic/i2c_byte.sv
`timescale 1ns/1ns
module i2c_byte
(
    input logic     CLK,
    input logic     RESET,
    byte_if.shifter b
);

    logic                           active;
    logic                           ready;
    logic [eeprom_pkg::PHASE_W-1:0] phase;
    logic [1:0]                     quarter;
    logic [3:0]                     bit_cnt;
    logic                           rx_r;
    logic                           nack_r;
    logic                           ack_bit;
    eeprom_pkg::data_t              sh;

    assign quarter = 2'(phase / eeprom_pkg::QUARTER_CYCLES);
    assign b.done  = active && (bit_cnt == eeprom_pkg::ACK_BIT)
                     && (phase == eeprom_pkg::PHASE_LAST);
    assign ready   = !active || b.done;     // next byte may start on the done cycle

    assign b.rx_byte   = sh;
    assign b.slave_ack = !ack_bit;
    assign b.scl       = active && ((quarter == 2'd1) || (quarter == 2'd2));

    always_comb
    begin
        if (!active)
            b.sda_out = 1'b1;
        else if (bit_cnt == eeprom_pkg::ACK_BIT)
            b.sda_out = rx_r ? nack_r : 1'b1;   // release for slave ack
        else
            b.sda_out = rx_r ? 1'b1 : sh[7];
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            phase   <= '0;
            bit_cnt <= '0;
        end
        else if (b.go && ready)
        begin
            active  <= 1'b1;
            phase   <= '0;
            bit_cnt <= '0;
        end
        else if (active)
        begin
            if (phase == eeprom_pkg::PHASE_LAST)
            begin
                phase <= '0;
                if (bit_cnt == eeprom_pkg::ACK_BIT)
                    active <= 1'b0;
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else
                phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (b.go && ready)
        begin
            sh     <= b.rx_mode ? '0 : b.tx_byte;
            rx_r   <= b.rx_mode;
            nack_r <= b.master_nack;
        end
        else if (active && (bit_cnt != eeprom_pkg::ACK_BIT))
        begin
            if (rx_r && (phase == eeprom_pkg::PHASE_SAMPLE))
                sh <= {sh[6:0], b.sda_in};      // msb first
            else if (!rx_r && (phase == eeprom_pkg::PHASE_LAST))
                sh <= {sh[6:0], 1'b0};
        end

        if (active && (bit_cnt == eeprom_pkg::ACK_BIT) && (phase == eeprom_pkg::PHASE_SAMPLE))
            ack_bit <= b.sda_in;
    end

    // data may only move while scl is low
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (active && $past(active) && b.scl && $past(b.scl)) |-> $stable(b.sda_out));

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        b.done |=> !b.done);

endmodule

//--- logic/eeprom_seq.sv
`timescale 1ns/1ns
module eeprom_seq
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t data_in,
    byte_if.seq               b,
    cond_if.seq               c,
    output logic              scl,
    output logic              sda_out,
    output logic              ack,
    output logic              nack,
    output eeprom_pkg::data_t data_out
);

    logic [3:0]             state;
    logic [3:0]             state_nx;
    logic                   accept;
    logic                   entering;
    logic                   kick;       // first cycle of Start
    logic                   op_rd;
    logic                   tx_state;
    logic                   byte_on;
    logic                   cond_on;
    eeprom_pkg::addr_t      addr_r;
    eeprom_pkg::data_t      data_r;
    eeprom_pkg::ctrl_byte_u ctrl;

    assign accept   = (state == eeprom_pkg::ST_IDLE) && (wr || rd);
    assign entering = (state_nx != state);
    assign tx_state = state inside {eeprom_pkg::ST_CTRL, eeprom_pkg::ST_ADDR,
                                    eeprom_pkg::ST_DATA, eeprom_pkg::ST_CTRL_RD};
    assign byte_on  = tx_state || (state == eeprom_pkg::ST_READ);
    assign cond_on  = state inside {eeprom_pkg::ST_START, eeprom_pkg::ST_RESTART,
                                    eeprom_pkg::ST_STOP};

    always_comb
    begin
        state_nx = state;
        case (state)
            eeprom_pkg::ST_IDLE:
                if (wr || rd)
                    state_nx = eeprom_pkg::ST_START;
            eeprom_pkg::ST_START:
                if (c.done)
                    state_nx = eeprom_pkg::ST_CTRL;
            eeprom_pkg::ST_CTRL:
                if (b.done)
                    state_nx = b.slave_ack ? eeprom_pkg::ST_ADDR : eeprom_pkg::ST_STOP;
            eeprom_pkg::ST_ADDR:
                if (b.done)
                begin
                    if (!b.slave_ack)
                        state_nx = eeprom_pkg::ST_STOP;
                    else if (op_rd)
                        state_nx = eeprom_pkg::ST_RESTART;
                    else
                        state_nx = eeprom_pkg::ST_DATA;
                end
            eeprom_pkg::ST_DATA, eeprom_pkg::ST_READ:
                if (b.done)
                    state_nx = eeprom_pkg::ST_STOP;
            eeprom_pkg::ST_RESTART:
                if (c.done)
                    state_nx = eeprom_pkg::ST_CTRL_RD;
            eeprom_pkg::ST_CTRL_RD:
                if (b.done)
                    state_nx = b.slave_ack ? eeprom_pkg::ST_READ : eeprom_pkg::ST_STOP;
            eeprom_pkg::ST_STOP:
                if (c.done)
                    state_nx = eeprom_pkg::ST_DONE;
            default:
                state_nx = eeprom_pkg::ST_IDLE;
        endcase
    end

    // parts are launched on the cycle their state is entered
    assign b.go = entering && (state_nx inside {eeprom_pkg::ST_CTRL, eeprom_pkg::ST_ADDR,
                                                eeprom_pkg::ST_DATA, eeprom_pkg::ST_CTRL_RD,
                                                eeprom_pkg::ST_READ});
    assign c.go = kick || (entering && (state_nx inside {eeprom_pkg::ST_RESTART,
                                                         eeprom_pkg::ST_STOP}));

    assign c.kind = (state_nx == eeprom_pkg::ST_STOP)    ? eeprom_pkg::COND_STOP    :
                    (state_nx == eeprom_pkg::ST_RESTART) ? eeprom_pkg::COND_RESTART :
                                                           eeprom_pkg::COND_START;

    assign b.rx_mode     = (state_nx == eeprom_pkg::ST_READ);
    assign b.master_nack = 1'b1;        // single byte read ends with no-ack

    always_comb
    begin
        ctrl.f.dev_type = eeprom_pkg::DEV_TYPE;
        ctrl.f.page     = addr_r[10:8];
        ctrl.f.rw       = (state_nx == eeprom_pkg::ST_CTRL_RD);
    end

    always_comb
    begin
        case (state_nx)
            eeprom_pkg::ST_ADDR: b.tx_byte = addr_r[7:0];
            eeprom_pkg::ST_DATA: b.tx_byte = data_r;
            default:             b.tx_byte = ctrl.raw;
        endcase
    end

    // line mux, idle bus when neither part owns it
    assign scl     = byte_on ? b.scl     : (cond_on ? c.scl     : 1'b1);
    assign sda_out = byte_on ? b.sda_out : (cond_on ? c.sda_out : 1'b1);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::ST_IDLE;
            kick  <= 1'b0;
            ack   <= 1'b0;
            nack  <= 1'b0;
            op_rd <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            kick  <= accept;
            ack   <= (state == eeprom_pkg::ST_STOP) && c.done;
            if (accept)
            begin
                op_rd <= !wr;       // wr wins
                nack  <= 1'b0;
            end
            else if (tx_state && b.done && !b.slave_ack)
                nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r <= addr;
            data_r <= data_in;
        end
        if ((state == eeprom_pkg::ST_READ) && b.done)
            data_out <= b.rx_byte;
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // one part on the bus at a time
    a_one_go: assert property (@(posedge CLK) disable iff (RESET)
        !(b.go && c.go));

endmodule

//--- logic/eeprom_wr.sv
`timescale 1ns/1ns
module eeprom_wr
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t data_in,
    output logic              scl,
    inout  wire               sda,
    output logic              ack,
    output logic              nack,
    output eeprom_pkg::data_t data_out
);

    logic sda_out;

    byte_if byte_bus();
    cond_if cond_bus();

    // open drain, the pullup sits outside
    assign sda = sda_out ? 1'bz : 1'b0;
    assign byte_bus.sda_in = sda;

    i2c_cond u_cond
    (
        .CLK   (CLK),
        .RESET (RESET),
        .c     (cond_bus.gen)
    );

    i2c_byte u_byte
    (
        .CLK   (CLK),
        .RESET (RESET),
        .b     (byte_bus.shifter)
    );

    eeprom_seq u_seq
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .b        (byte_bus.seq),
        .c        (cond_bus.seq),
        .scl      (scl),
        .sda_out  (sda_out),
        .ack      (ack),
        .nack     (nack),
        .data_out (data_out)
    );

endmodule

//--- verification/eeprom_model.sv
`timescale 1ns/1ns
module eeprom_model
(
    input  logic              scl,
    inout  wire               sda,
    input  eeprom_pkg::addr_t nack_base,    // first address of the silent window
    output logic              error
);

    typedef enum int {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_READ, M_SKIP} mode_e;

    logic [7:0]        mem [0:2047];
    logic              pull_low;
    logic              restarted;
    int                bit_cnt;
    logic [7:0]        sh;
    logic [2:0]        page;
    eeprom_pkg::addr_t ptr;
    mode_e             mode;

    assign sda = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        pull_low  = 1'b0;
        error     = 1'b0;
        restarted = 1'b0;
        bit_cnt   = 0;
        mode      = M_IDLE;
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ {5'b0, a[10:8]} ^ 8'h5A;
    end

    task automatic protocol_error(input string what);
        $display("eeprom model: protocol error at %0t ns, %s", $time, what);
        error = 1'b1;
    endtask

    // called on the scl fall after the eighth bit of a byte
    task byte_end;
        case (mode)
            M_CTRL:
            begin
                if (sh[7:4] != eeprom_pkg::DEV_TYPE)
                    protocol_error("the control byte carries a wrong device type code");
                else if (sh[0] != restarted)
                    protocol_error("the read bit of the control byte is wrong");
                page     = sh[3:1];
                mode     = sh[0] ? M_READ : M_ADDR;
                pull_low = 1'b1;
            end
            M_ADDR:
            begin
                ptr = {page, sh};
                if (eeprom_pkg::addr_t'(ptr - nack_base) < 16)
                    mode = M_SKIP;      // stays silent
                else
                begin
                    mode     = M_DATA;
                    pull_low = 1'b1;
                end
            end
            M_DATA:
            begin
                mem[ptr] = sh;
                mode     = M_SKIP;
                pull_low = 1'b1;
            end
            M_READ:
            begin
                mode     = M_SKIP;      // master answers the read byte
                pull_low = 1'b0;
            end
            default:
                pull_low = 1'b0;
        endcase
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            if ((mode != M_IDLE) && (bit_cnt > 1))
                protocol_error("SDA fell while SCL was high in the middle of a byte");
            restarted = (mode != M_IDLE);
            mode      = M_CTRL;
            bit_cnt   = 0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            if ((mode != M_IDLE) && (bit_cnt > 1))
                protocol_error("SDA rose while SCL was high in the middle of a byte");
            mode    = M_IDLE;
            bit_cnt = 0;
        end
    end

    always @(posedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (bit_cnt < 8)
                sh = {sh[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (bit_cnt == 8)
                byte_end();
            else if (bit_cnt == 9)
            begin
                bit_cnt  = 0;
                pull_low = 1'b0;
            end
            if ((mode == M_READ) && (bit_cnt < 8))
                pull_low = !mem[ptr][7 - bit_cnt];   // msb first
        end
    end

endmodule

//--- verification/tb_eeprom_wr.sv
`timescale 1ns/1ns
module tb_eeprom_wr;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    eeprom_pkg::addr_t addr;
    eeprom_pkg::data_t data_in;
    eeprom_pkg::data_t data_out;
    logic              scl;
    logic              ack;
    logic              nack;
    wire               sda;
    logic              model_err;
    eeprom_pkg::addr_t win_base;
    eeprom_pkg::data_t ref_mem [0:2047];
    logic              touched [0:2047];

    pullup (sda);

    eeprom_wr u_dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .scl      (scl),
        .sda      (sda),
        .ack      (ack),
        .nack     (nack),
        .data_out (data_out)
    );

    eeprom_model u_mem
    (
        .scl       (scl),
        .sda       (sda),
        .nack_base (win_base),
        .error     (model_err)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge model_err)
        abort_run("the EEPROM model saw a bus protocol error");

    task automatic check_data(input string name, input eeprom_pkg::data_t got,
                              input eeprom_pkg::data_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %0t ns %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %0t ns %s got %b expected %b", $time, name, got, exp));
    endtask

    // initial contents of the part
    function automatic eeprom_pkg::data_t fill_value(input eeprom_pkg::addr_t a);
        return a[7:0] ^ {5'b0, a[10:8]} ^ 8'h5A;
    endfunction

    function automatic logic in_window(input eeprom_pkg::addr_t a);
        eeprom_pkg::addr_t off;
        off = a - win_base;
        return off < 16;
    endfunction

    function automatic eeprom_pkg::addr_t pick_outside(input logic [2:0] page);
        eeprom_pkg::addr_t a;
        a = {page, 8'($urandom)};
        while (in_window(a))
            a = {page, 8'($urandom)};
        return a;
    endfunction

    task automatic strobe(input logic w, input logic r, input eeprom_pkg::addr_t a,
                          input eeprom_pkg::data_t d);
        wr      = w;
        rd      = r;
        addr    = a;
        data_in = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack;
        int n;
        n = 0;
        while ((ack !== 1'b1) && (n < 500))
        begin
            @(negedge CLK);
            n++;
        end
        if (ack !== 1'b1)
            abort_run("the DUT gave no ack within 500 cycles");
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge CLK);
            check_flag("ack", ack, 1'b0);
        end
    endtask

    task automatic write_byte(input eeprom_pkg::addr_t a, input eeprom_pkg::data_t d);
        logic miss;
        miss = in_window(a);
        @(negedge CLK);         // step past the ack cycle
        strobe(1'b1, 1'b0, a, d);
        wait_ack();
        check_flag("nack", nack, miss);
        if (!miss)
        begin
            ref_mem[a] = d;
            touched[a] = 1'b1;
        end
    endtask

    task automatic read_byte(input eeprom_pkg::addr_t a);
        logic miss;
        miss = in_window(a);
        @(negedge CLK);
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_ack();
        check_flag("nack", nack, miss);
        if (!miss)
            check_data("data_out", data_out, ref_mem[a]);
    endtask

    initial
    begin
        eeprom_pkg::addr_t a;
        eeprom_pkg::addr_t a2;
        eeprom_pkg::data_t d;
        eeprom_pkg::addr_t used [$];

        void'($urandom(50));
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        data_in  = '0;
        RESET    = 1'b1;
        win_base = 11'($urandom % 2032);
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = fill_value(11'(i));
            touched[i] = 1'b0;
        end

        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);
        check_flag("ack", ack, 1'b0);
        check_flag("nack", nack, 1'b0);

        // every page bit pattern gets written
        for (int i = 0; i < 24; i++)
        begin
            a = pick_outside(3'(i));
            write_byte(a, 8'($urandom));
            used.push_back(a);
        end
        foreach (used[i])
            read_byte(used[i]);

        a = pick_outside(3'($urandom));
        while (touched[a])
            a = pick_outside(3'($urandom));
        read_byte(a);

        // silent window
        a = win_base + 11'($urandom % 16);
        write_byte(a, 8'($urandom));
        read_byte(a);
        read_byte(used[0]);

        // strobes while busy are dropped
        a  = pick_outside(3'($urandom));
        a2 = pick_outside(3'($urandom));
        while (a2 == a)
            a2 = pick_outside(3'($urandom));
        d = 8'($urandom);
        @(negedge CLK);
        strobe(1'b1, 1'b0, a, d);
        repeat (20) @(negedge CLK);
        strobe(1'b0, 1'b1, a2, 8'h00);
        repeat (30) @(negedge CLK);
        strobe(1'b1, 1'b0, a2, ~ref_mem[a2]);
        wait_ack();
        check_flag("nack", nack, 1'b0);
        ref_mem[a] = d;
        touched[a] = 1'b1;
        expect_quiet(200);
        read_byte(a);
        read_byte(a2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- eeprom_wr.f
logic/eeprom_pkg.sv
logic/byte_if.sv
logic/cond_if.sv
logic/i2c_cond.sv
logic/i2c_byte.sv
logic/eeprom_seq.sv
logic/eeprom_wr.sv
verification/eeprom_model.sv
verification/tb_eeprom_wr.sv
